//--- bench/axil_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_model
  (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic [31:0] awaddr_i,
    input  wire logic        awvalid_i,
    output logic             awready_o,
    input  wire logic [31:0] wdata_i,
    input  wire logic [3:0]  wstrb_i,
    input  wire logic        wvalid_i,
    output logic             wready_o,
    output logic [1:0]       bresp_o,
    output logic             bvalid_o,
    input  wire logic        bready_i,
    input  wire logic [31:0] araddr_i,
    input  wire logic        arvalid_i,
    output logic             arready_o,
    output logic [31:0]      rdata_o,
    output logic [1:0]       rresp_o,
    output logic             rvalid_o,
    input  wire logic        rready_i
  );

  // SLVERR from here up, and no B or R at all from the stall base up
  localparam logic [31:0] ERR_BASE   = 32'h8000_0000;
  localparam logic [31:0] STALL_BASE = 32'hF000_0000;

  logic [31:0] mem [256];
  integer      seed;

  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  // Ends one ns after a rising edge, where outputs change
  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic serve_write();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          aw_wait;
    int          w_wait;
    logic        aw_open;
    logic        w_open;
    addr    = awaddr_i;
    data    = wdata_i;
    strb    = wstrb_i;
    aw_wait = pick_delay();
    w_wait  = pick_delay();
    aw_open = 1'b1;
    w_open  = 1'b1;
    wait_cycles(1);
    // AW and W each accept after their own delay
    while (aw_open || w_open)
    begin
      awready_o = aw_open && (aw_wait == 0);
      wready_o  = w_open && (w_wait == 0);
      @(posedge clk_i);
      if (awready_o)
        aw_open = 1'b0;
      if (wready_o)
        w_open = 1'b0;
      if (aw_wait > 0)
        aw_wait--;
      if (w_wait > 0)
        w_wait--;
      #1;
    end
    awready_o = 1'b0;
    wready_o  = 1'b0;
    if (addr < ERR_BASE)
    begin
      for (int b = 0; b < 4; b++)
        if (strb[b])
          mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
    end
    wait_cycles(pick_delay());
    if (addr >= STALL_BASE)
      return;
    bresp_o  = (addr >= ERR_BASE) ? 2'b10 : 2'b00;
    bvalid_o = 1'b1;
    // Bready depends only on bridge state, so it is settled at the falling edge
    @(negedge clk_i);
    while (!bready_i)
      @(negedge clk_i);
    wait_cycles(1);
    bvalid_o = 1'b0;
    bresp_o  = 2'b00;
  endtask

  task automatic serve_read();
    logic [31:0] addr;
    addr = araddr_i;
    wait_cycles(1 + pick_delay());
    arready_o = 1'b1;
    wait_cycles(1);
    arready_o = 1'b0;
    wait_cycles(pick_delay());
    if (addr >= STALL_BASE)
      return;
    if (addr >= ERR_BASE)
    begin
      rresp_o = 2'b10;
      // Junk data that the bridge has to discard
      rdata_o = 32'hDEAD_0BAD ^ addr;
    end
    else
    begin
      rresp_o = 2'b00;
      rdata_o = mem[addr[9:2]];
    end
    rvalid_o = 1'b1;
    @(negedge clk_i);
    while (!rready_i)
      @(negedge clk_i);
    wait_cycles(1);
    rvalid_o = 1'b0;
    rresp_o  = 2'b00;
    rdata_o  = 32'h0;
  endtask

  initial
  begin
    seed = 32'h21bf6666;
    for (int i = 0; i < 256; i++)
      mem[i] = {8'h5A, 8'(i), 8'(~i), 8'(i * 7)};
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bresp_o   = 2'b00;
    bvalid_o  = 1'b0;
    arready_o = 1'b0;
    rdata_o   = 32'h0;
    rresp_o   = 2'b00;
    rvalid_o  = 1'b0;
    // The bridge raises AW and W together, one transaction at a time
    forever
    begin
      @(negedge clk_i);
      if (!rst_i && awvalid_i && wvalid_i)
        serve_write();
      else if (!rst_i && arvalid_i)
        serve_read();
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_mem_axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module tb_mem_axil_bridge;

  import axil_bridge_pkg::*;

  localparam logic [31:0] ERR_BASE = 32'h8000_0000;

  // Requests per test, used to size the watchdog
  localparam int REQS_WORD   = 2;
  localparam int REQS_MERGE  = 5;
  localparam int REQS_NARROW = 5;
  localparam int REQS_BURST  = 8;
  localparam int REQS_ERROR  = 2;
  localparam int REQS_STALL  = 4;
  localparam int NUM_REQS    = REQS_WORD + REQS_MERGE + REQS_NARROW + REQS_BURST +
                               REQS_ERROR + REQS_STALL;
  localparam int WATCHDOG_CYCLES = NUM_REQS * (`RESP_TIMEOUT + 20);

  logic        clk = 1'b0;
  logic        rst;
  mem_req_s    mem_req;
  logic        mem_req_v;
  logic        mem_req_ready;
  mem_resp_s   mem_resp;
  logic        mem_resp_v;
  logic        mem_resp_ready;
  logic [31:0] awaddr;
  logic [2:0]  awprot;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic [2:0]  arprot;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int          errors;
  integer      seed;
  logic [31:0] shadow [256];
  mem_resp_s   expected_q [$];
  logic        data_known_q [$];

  always #10 clk = ~clk;

  mem_axil_bridge dut_i
  (
    .clk_i            (clk),
    .rst_i            (rst),
    .mem_req_i        (mem_req),
    .mem_req_v_i      (mem_req_v),
    .mem_req_ready_o  (mem_req_ready),
    .mem_resp_o       (mem_resp),
    .mem_resp_v_o     (mem_resp_v),
    .mem_resp_ready_i (mem_resp_ready),
    .m_axil_awaddr_o  (awaddr),
    .m_axil_awprot_o  (awprot),
    .m_axil_awvalid_o (awvalid),
    .m_axil_awready_i (awready),
    .m_axil_wdata_o   (wdata),
    .m_axil_wstrb_o   (wstrb),
    .m_axil_wvalid_o  (wvalid),
    .m_axil_wready_i  (wready),
    .m_axil_bresp_i   (bresp),
    .m_axil_bvalid_i  (bvalid),
    .m_axil_bready_o  (bready),
    .m_axil_araddr_o  (araddr),
    .m_axil_arprot_o  (arprot),
    .m_axil_arvalid_o (arvalid),
    .m_axil_arready_i (arready),
    .m_axil_rdata_i   (rdata),
    .m_axil_rresp_i   (rresp),
    .m_axil_rvalid_i  (rvalid),
    .m_axil_rready_o  (rready)
  );

  axil_mem_model mem_model_i
  (
    .clk_i     (clk),
    .rst_i     (rst),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bresp_o   (bresp),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rvalid_o  (rvalid),
    .rready_i  (rready)
  );

  // Aligned lanes take the low data bytes in order
  function automatic logic [31:0] merge_write(input logic [31:0] old_word, input mem_size_e size,
                                              input logic [1:0] offset, input logic [31:0] data);
    logic [31:0] word;
    int          nbytes;
    int          first;
    word   = old_word;
    nbytes = 1 << int'(size);
    first  = (int'(offset) / nbytes) * nbytes;
    for (int b = 0; b < nbytes; b++)
      word[8*(first + b) +: 8] = data[8*b +: 8];
    return word;
  endfunction

  function automatic logic [31:0] narrow_read(input logic [31:0] word, input mem_size_e size,
                                              input logic [1:0] offset);
    logic [31:0] result;
    int          nbytes;
    int          first;
    nbytes = 1 << int'(size);
    first  = (int'(offset) / nbytes) * nbytes;
    for (int b = 0; b < 4; b++)
      result[8*b +: 8] = word[8*(first + (b % nbytes)) +: 8];
    return result;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Called one ns after an edge; holds valid until the FIFO takes the request
  task automatic send_req(input mem_op_e op, input mem_size_e size, input logic [31:0] addr,
                          input logic [3:0] tag, input logic [31:0] data, output int stalls);
    stalls           = 0;
    mem_req.hdr.op   = op;
    mem_req.hdr.size = size;
    mem_req.hdr.addr = addr;
    mem_req.hdr.tag  = tag;
    mem_req.data     = data;
    mem_req_v        = 1'b1;
    while (!mem_req_ready)
    begin
      stalls++;
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    mem_req_v = 1'b0;
  endtask

  task automatic issue(input mem_op_e op, input mem_size_e size, input logic [31:0] addr,
                       input logic [3:0] tag, input logic [31:0] data, output int stalls);
    mem_resp_s exp;
    exp.hdr.op   = op;
    exp.hdr.size = size;
    exp.hdr.addr = addr;
    exp.hdr.tag  = tag;
    exp.err      = (addr >= ERR_BASE);
    exp.data     = 32'h0;
    if (!exp.err && op == MEM_OP_WRITE)
      shadow[addr[9:2]] = merge_write(shadow[addr[9:2]], size, addr[1:0], data);
    else if (!exp.err)
      exp.data = narrow_read(shadow[addr[9:2]], size, addr[1:0]);
    expected_q.push_back(exp);
    // Write data in a good response is not defined
    data_known_q.push_back(exp.err || op == MEM_OP_READ);
    send_req(op, size, addr, tag, data, stalls);
  endtask

  task automatic compare_resp(input mem_resp_s got, input mem_resp_s exp, input logic data_known);
    string label;
    label = $sformatf("response tag %0h", exp.hdr.tag);
    check_value({label, " tag"}, 32'(got.hdr.tag), 32'(exp.hdr.tag));
    check_value({label, " op"}, 32'(got.hdr.op), 32'(exp.hdr.op));
    check_value({label, " size"}, 32'(got.hdr.size), 32'(exp.hdr.size));
    check_value({label, " address"}, got.hdr.addr, exp.hdr.addr);
    check_value({label, " err"}, 32'(got.err), 32'(exp.err));
    if (data_known)
      check_value({label, " data"}, got.data, exp.data);
  endtask

  task automatic collect(input int count, input logic random_ready);
    mem_resp_s exp;
    logic      data_known;
    int        got;
    got = 0;
    while (got < count)
    begin
      mem_resp_ready = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
      if (mem_resp_ready && mem_resp_v)
      begin
        exp        = expected_q.pop_front();
        data_known = data_known_q.pop_front();
        compare_resp(mem_resp, exp, data_known);
        got++;
      end
      @(posedge clk);
      #1;
    end
    mem_resp_ready = 1'b0;
  endtask

  task automatic access(input mem_op_e op, input mem_size_e size, input logic [31:0] addr,
                        input logic [3:0] tag, input logic [31:0] data);
    int stalls;
    issue(op, size, addr, tag, data, stalls);
    collect(1, 1'b0);
  endtask

  task automatic word_write_read();
    access(MEM_OP_WRITE, MEM_SIZE_4, 32'h0000_0010, 4'h1, 32'hDEAD_BEEF);
    access(MEM_OP_READ, MEM_SIZE_4, 32'h0000_0010, 4'h2, 32'h0);
    check_value("awprot", 32'(awprot), 32'h0);
    check_value("arprot", 32'(arprot), 32'h0);
  endtask

  task automatic byte_merge();
    access(MEM_OP_WRITE, MEM_SIZE_4, 32'h0000_0020, 4'h3, 32'h1122_3344);
    access(MEM_OP_WRITE, MEM_SIZE_1, 32'h0000_0021, 4'h4, 32'h0000_00AB);
    // Odd halfword address lands on the upper half
    access(MEM_OP_WRITE, MEM_SIZE_2, 32'h0000_0023, 4'h5, 32'h0000_CDEF);
    access(MEM_OP_WRITE, MEM_SIZE_1, 32'h0000_0020, 4'h6, 32'hFFFF_FF5A);
    access(MEM_OP_READ, MEM_SIZE_4, 32'h0000_0020, 4'h7, 32'h0);
  endtask

  task automatic narrow_reads();
    access(MEM_OP_WRITE, MEM_SIZE_4, 32'h0000_0030, 4'h8, 32'h8899_AABB);
    access(MEM_OP_READ, MEM_SIZE_1, 32'h0000_0031, 4'h9, 32'h0);
    access(MEM_OP_READ, MEM_SIZE_1, 32'h0000_0033, 4'hA, 32'h0);
    access(MEM_OP_READ, MEM_SIZE_2, 32'h0000_0030, 4'hB, 32'h0);
    access(MEM_OP_READ, MEM_SIZE_2, 32'h0000_0033, 4'hC, 32'h0);
  endtask

  task automatic ordered_burst();
    int   stalls;
    logic saw_full;
    saw_full = 1'b0;
    fork
      begin
        // Four word writes, then mixed-size reads of the same words
        for (int i = 0; i < REQS_BURST; i++)
        begin
          if (i < 4)
            issue(MEM_OP_WRITE, MEM_SIZE_4, 32'h100 + 32'(4 * i), 4'(i),
                  32'h1357_9BDF ^ (32'(i) * 32'h0101_0101), stalls);
          else
            issue(MEM_OP_READ, mem_size_e'(i % 3), 32'h100 + 32'(4 * (i - 4) + i % 4),
                  4'(i), 32'h0, stalls);
          if (stalls > 0)
            saw_full = 1'b1;
        end
      end
      collect(REQS_BURST, 1'b1);
    join
    check_value("request ready dropped during burst", 32'(saw_full), 32'h1);
  endtask

  task automatic error_region();
    access(MEM_OP_WRITE, MEM_SIZE_4, 32'h8000_0040, 4'hD, 32'h5555_AAAA);
    access(MEM_OP_READ, MEM_SIZE_1, 32'h8000_0045, 4'hE, 32'h0);
  endtask

  task automatic stall_then_recover();
    access(MEM_OP_READ, MEM_SIZE_4, 32'hF000_0000, 4'hF, 32'h0);
    access(MEM_OP_WRITE, MEM_SIZE_4, 32'hF000_0010, 4'h0, 32'h1234_5678);
    // Normal traffic after the timeouts
    access(MEM_OP_WRITE, MEM_SIZE_4, 32'h0000_0050, 4'h1, 32'h0BAD_F00D);
    access(MEM_OP_READ, MEM_SIZE_4, 32'h0000_0050, 4'h2, 32'h0);
  endtask

  initial
  begin
    errors         = 0;
    seed           = 32'h21bf6666;
    rst            = 1'b1;
    mem_req        = '0;
    mem_req_v      = 1'b0;
    mem_resp_ready = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    word_write_read();
    byte_merge();
    narrow_reads();
    ordered_burst();
    error_region();
    stall_then_recover();
    check_value("response valid after the last request", 32'(mem_resp_v), 32'h0);
    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin
    repeat (3 + WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the bridge stopped answering",
             WATCHDOG_CYCLES);
    $display("Run stopped with %0d errors", errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/axil_bridge_pkg.sv
verilog/mem_fifo.sv
verilog/axil_strobe_gen.sv
verilog/axil_read_pack.sv
verilog/axil_resp_timer.sv
verilog/axil_txn_fsm.sv
verilog/mem_axil_bridge.sv
bench/axil_mem_model.sv
bench/tb_mem_axil_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_mem_axil_bridge -Mdir obj_dir -f filelist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_mem_axil_bridge > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF -- "** FAIL **" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- verilog/axil_bridge_defines.svh
`ifndef AXIL_BRIDGE_DEFINES_SVH
`define AXIL_BRIDGE_DEFINES_SVH

// AXI-Lite bus widths
`define AXIL_DATA_W 32
`define AXIL_ADDR_W 32

// Entries in each of the request and response FIFOs
`define MEM_FIFO_DEPTH 2

// Cycles to wait on B or R before giving up
`define RESP_TIMEOUT 64

`endif

//--- verilog/axil_bridge_pkg.sv
`default_nettype none

`include "axil_bridge_defines.svh"

package axil_bridge_pkg;

  // Memory operation, one bit
  typedef enum logic
  {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_e;

  // Access size as log2 of the byte count
  typedef enum logic [1:0]
  {
    MEM_SIZE_1 = 2'd0,
    MEM_SIZE_2 = 2'd1,
    MEM_SIZE_4 = 2'd2
  } mem_size_e;

  // Request header, 39 bits
  typedef struct packed
  {
    mem_op_e                 op;
    mem_size_e               size;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [3:0]              tag;
  } mem_hdr_s;

  // Header plus one data word
  typedef struct packed
  {
    mem_hdr_s                hdr;
    logic [`AXIL_DATA_W-1:0] data;
  } mem_req_s;

  // Echoed header, read data and error flag
  typedef struct packed
  {
    mem_hdr_s                hdr;
    logic [`AXIL_DATA_W-1:0] data;
    logic                    err;
  } mem_resp_s;

endpackage

`default_nettype wire

//--- verilog/axil_read_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module axil_read_pack
  (
    input  wire axil_bridge_pkg::mem_size_e size_i,
    input  wire logic [1:0]                 addr_i,
    input  wire logic [`AXIL_DATA_W-1:0]    rdata_i,
    output logic [`AXIL_DATA_W-1:0]         data_o
  );

  import axil_bridge_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign sel_byte = rdata_i[{addr_i, 3'b000} +: 8];
  // Halfword select ignores address bit 0
  assign sel_half = addr_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  always_comb
  begin
    case (size_i)
      MEM_SIZE_1: data_o = {4{sel_byte}};
      MEM_SIZE_2: data_o = {2{sel_half}};
      default:    data_o = rdata_i;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/axil_resp_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module axil_resp_timer
  (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic start_i,
    input  wire logic run_i,
    output logic      expired_o
  );

  localparam int CNT_W = $clog2(`RESP_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] LOAD = CNT_W'(`RESP_TIMEOUT);

  logic [CNT_W-1:0] count_r;

  // Saturates at zero until the next start
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      count_r <= LOAD;
    else if (start_i)
      count_r <= LOAD;
    else if (run_i && (count_r != '0))
      count_r <= count_r - 1'b1;
  end

  assign expired_o = (count_r == '0);

  // A new wait may not begin while one is still counting
  a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> !(run_i && (count_r != '0)));

endmodule

`default_nettype wire

//--- verilog/axil_strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module axil_strobe_gen
  (
    input  wire axil_bridge_pkg::mem_size_e size_i,
    input  wire logic [`AXIL_ADDR_W-1:0]    addr_i,
    input  wire logic [`AXIL_DATA_W-1:0]    data_i,
    output logic [`AXIL_DATA_W/8-1:0]       wstrb_o,
    output logic [`AXIL_DATA_W-1:0]         wdata_o,
    output logic [`AXIL_ADDR_W-1:0]         awaddr_o
  );

  import axil_bridge_pkg::*;

  logic [`AXIL_ADDR_W-1:0] align_mask;
  logic [1:0]              byte_off;

  always_comb
  begin
    case (size_i)
      MEM_SIZE_1:
      begin
        align_mask = '1;
        wdata_o    = {4{data_i[7:0]}};
      end
      MEM_SIZE_2:
      begin
        align_mask = {{(`AXIL_ADDR_W-1){1'b1}}, 1'b0};
        wdata_o    = {2{data_i[15:0]}};
      end
      default:
      begin
        align_mask = {{(`AXIL_ADDR_W-2){1'b1}}, 2'b00};
        wdata_o    = data_i;
      end
    endcase
  end

  assign awaddr_o = addr_i & align_mask;
  assign byte_off = awaddr_o[1:0];

  // Lane mask for the access width, moved to its byte offset
  always_comb
  begin
    case (size_i)
      MEM_SIZE_1: wstrb_o = 4'h1 << byte_off;
      MEM_SIZE_2: wstrb_o = 4'h3 << byte_off;
      default:    wstrb_o = 4'hF;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/axil_txn_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module axil_txn_fsm
  (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire logic                      req_v_i,
    input  wire axil_bridge_pkg::mem_req_s req_i,
    output logic                           req_yumi_o,
    input  wire logic                      resp_ready_i,
    output logic                           resp_push_o,
    output axil_bridge_pkg::mem_resp_s     resp_o,
    output logic                           timer_start_o,
    output logic                           timer_run_o,
    input  wire logic                      expired_i,
    output logic [`AXIL_ADDR_W-1:0]        awaddr_o,
    output logic                           awvalid_o,
    input  wire logic                      awready_i,
    output logic [`AXIL_DATA_W-1:0]        wdata_o,
    output logic [`AXIL_DATA_W/8-1:0]      wstrb_o,
    output logic                           wvalid_o,
    input  wire logic                      wready_i,
    input  wire logic [1:0]                bresp_i,
    input  wire logic                      bvalid_i,
    output logic                           bready_o,
    output logic [`AXIL_ADDR_W-1:0]        araddr_o,
    output logic                           arvalid_o,
    input  wire logic                      arready_i,
    input  wire logic [`AXIL_DATA_W-1:0]   rdata_i,
    input  wire logic [1:0]                rresp_i,
    input  wire logic                      rvalid_i,
    output logic                           rready_o
  );

  import axil_bridge_pkg::*;

  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_WR_ADDR,
    ST_WR_RESP,
    ST_RD_ADDR,
    ST_RD_DATA,
    ST_RESPOND
  } state_e;

  state_e                  state_r;
  mem_hdr_s                hdr_r;
  logic [`AXIL_DATA_W-1:0] wdata_r;
  logic [`AXIL_DATA_W-1:0] resp_data_r;
  logic                    err_r;
  logic                    awvalid_r;
  logic                    wvalid_r;
  logic                    arvalid_r;
  logic [`AXIL_ADDR_W-1:0] aligned_addr;
  logic [`AXIL_DATA_W-1:0] rdata_packed;
  logic                    aw_done;
  logic                    w_done;

  axil_strobe_gen strobe_gen_i
  (
    .size_i   (hdr_r.size),
    .addr_i   (hdr_r.addr),
    .data_i   (wdata_r),
    .wstrb_o  (wstrb_o),
    .wdata_o  (wdata_o),
    .awaddr_o (aligned_addr)
  );

  axil_read_pack read_pack_i
  (
    .size_i  (hdr_r.size),
    .addr_i  (hdr_r.addr[1:0]),
    .rdata_i (rdata_i),
    .data_o  (rdata_packed)
  );

  // AW and W finish independently; both done ends the address phase
  assign aw_done = !awvalid_r || awready_i;
  assign w_done  = !wvalid_r || wready_i;

  assign req_yumi_o    = (state_r == ST_IDLE) && req_v_i;
  assign resp_push_o   = (state_r == ST_RESPOND) && resp_ready_i;
  assign timer_start_o = ((state_r == ST_WR_ADDR) && aw_done && w_done) ||
                         ((state_r == ST_RD_ADDR) && arready_i);
  assign timer_run_o   = (state_r == ST_WR_RESP) || (state_r == ST_RD_DATA);
  assign bready_o      = (state_r == ST_WR_RESP);
  assign rready_o      = (state_r == ST_RD_DATA);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r   <= ST_IDLE;
      awvalid_r <= 1'b0;
      wvalid_r  <= 1'b0;
      arvalid_r <= 1'b0;
    end
    else
    begin
      case (state_r)
        ST_IDLE:
          if (req_v_i)
          begin
            if (req_i.hdr.op == MEM_OP_WRITE)
            begin
              awvalid_r <= 1'b1;
              wvalid_r  <= 1'b1;
              state_r   <= ST_WR_ADDR;
            end
            else
            begin
              arvalid_r <= 1'b1;
              state_r   <= ST_RD_ADDR;
            end
          end
        ST_WR_ADDR:
        begin
          if (awready_i)
            awvalid_r <= 1'b0;
          if (wready_i)
            wvalid_r <= 1'b0;
          if (aw_done && w_done)
            state_r <= ST_WR_RESP;
        end
        ST_WR_RESP:
          if (bvalid_i || expired_i)
            state_r <= ST_RESPOND;
        ST_RD_ADDR:
          if (arready_i)
          begin
            arvalid_r <= 1'b0;
            state_r   <= ST_RD_DATA;
          end
        ST_RD_DATA:
          if (rvalid_i || expired_i)
            state_r <= ST_RESPOND;
        ST_RESPOND:
          if (resp_ready_i)
            state_r <= ST_IDLE;
        default:
          state_r <= ST_IDLE;
      endcase
    end
  end

  // Latched request and the result returned with it
  always_ff @(posedge clk_i)
  begin
    if (req_yumi_o)
    begin
      hdr_r   <= req_i.hdr;
      wdata_r <= req_i.data;
    end
    if (state_r == ST_WR_RESP)
    begin
      if (bvalid_i)
      begin
        err_r       <= (bresp_i != 2'b00);
        resp_data_r <= '0;
      end
      else if (expired_i)
      begin
        err_r       <= 1'b1;
        resp_data_r <= '0;
      end
    end
    if (state_r == ST_RD_DATA)
    begin
      if (rvalid_i)
      begin
        err_r       <= (rresp_i != 2'b00);
        resp_data_r <= (rresp_i != 2'b00) ? '0 : rdata_packed;
      end
      else if (expired_i)
      begin
        err_r       <= 1'b1;
        resp_data_r <= '0;
      end
    end
  end

  assign resp_o.hdr  = hdr_r;
  assign resp_o.data = resp_data_r;
  assign resp_o.err  = err_r;

  assign awvalid_o = awvalid_r;
  assign wvalid_o  = wvalid_r;
  assign arvalid_o = arvalid_r;
  assign awaddr_o  = aligned_addr;
  assign araddr_o  = aligned_addr;

  a_aw_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (awvalid_o && !awready_i) |=> (awvalid_o && $stable(awaddr_o)));
  a_w_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (wvalid_o && !wready_i) |=> (wvalid_o && $stable(wdata_o) && $stable(wstrb_o)));
  a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)));

endmodule

`default_nettype wire

//--- verilog/mem_axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module mem_axil_bridge
  (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire axil_bridge_pkg::mem_req_s mem_req_i,
    input  wire logic                      mem_req_v_i,
    output logic                           mem_req_ready_o,
    output axil_bridge_pkg::mem_resp_s     mem_resp_o,
    output logic                           mem_resp_v_o,
    input  wire logic                      mem_resp_ready_i,
    output logic [`AXIL_ADDR_W-1:0]        m_axil_awaddr_o,
    output logic [2:0]                     m_axil_awprot_o,
    output logic                           m_axil_awvalid_o,
    input  wire logic                      m_axil_awready_i,
    output logic [`AXIL_DATA_W-1:0]        m_axil_wdata_o,
    output logic [`AXIL_DATA_W/8-1:0]      m_axil_wstrb_o,
    output logic                           m_axil_wvalid_o,
    input  wire logic                      m_axil_wready_i,
    input  wire logic [1:0]                m_axil_bresp_i,
    input  wire logic                      m_axil_bvalid_i,
    output logic                           m_axil_bready_o,
    output logic [`AXIL_ADDR_W-1:0]        m_axil_araddr_o,
    output logic [2:0]                     m_axil_arprot_o,
    output logic                           m_axil_arvalid_o,
    input  wire logic                      m_axil_arready_i,
    input  wire logic [`AXIL_DATA_W-1:0]   m_axil_rdata_i,
    input  wire logic [1:0]                m_axil_rresp_i,
    input  wire logic                      m_axil_rvalid_i,
    output logic                           m_axil_rready_o
  );

  import axil_bridge_pkg::*;

  mem_req_s  req_head;
  logic      req_v;
  logic      req_yumi;
  mem_resp_s resp_in;
  logic      resp_push;
  logic      resp_ready;
  logic      timer_start;
  logic      timer_run;
  logic      timer_expired;

  mem_fifo #(.payload_t(mem_req_s)) req_fifo_i
  (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (mem_req_v_i && mem_req_ready_o),
    .data_i  (mem_req_i),
    .yumi_i  (req_yumi),
    .ready_o (mem_req_ready_o),
    .v_o     (req_v),
    .data_o  (req_head)
  );

  axil_txn_fsm txn_fsm_i
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_v_i       (req_v),
    .req_i         (req_head),
    .req_yumi_o    (req_yumi),
    .resp_ready_i  (resp_ready),
    .resp_push_o   (resp_push),
    .resp_o        (resp_in),
    .timer_start_o (timer_start),
    .timer_run_o   (timer_run),
    .expired_i     (timer_expired),
    .awaddr_o      (m_axil_awaddr_o),
    .awvalid_o     (m_axil_awvalid_o),
    .awready_i     (m_axil_awready_i),
    .wdata_o       (m_axil_wdata_o),
    .wstrb_o       (m_axil_wstrb_o),
    .wvalid_o      (m_axil_wvalid_o),
    .wready_i      (m_axil_wready_i),
    .bresp_i       (m_axil_bresp_i),
    .bvalid_i      (m_axil_bvalid_i),
    .bready_o      (m_axil_bready_o),
    .araddr_o      (m_axil_araddr_o),
    .arvalid_o     (m_axil_arvalid_o),
    .arready_i     (m_axil_arready_i),
    .rdata_i       (m_axil_rdata_i),
    .rresp_i       (m_axil_rresp_i),
    .rvalid_i      (m_axil_rvalid_i),
    .rready_o      (m_axil_rready_o)
  );

  axil_resp_timer resp_timer_i
  (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (timer_start),
    .run_i     (timer_run),
    .expired_o (timer_expired)
  );

  // Responses leave in request order
  mem_fifo #(.payload_t(mem_resp_s)) resp_fifo_i
  (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (resp_push),
    .data_i  (resp_in),
    .yumi_i  (mem_resp_v_o && mem_resp_ready_i),
    .ready_o (resp_ready),
    .v_o     (mem_resp_v_o),
    .data_o  (mem_resp_o)
  );

  // Unprivileged, secure, data accesses
  assign m_axil_awprot_o = 3'b000;
  assign m_axil_arprot_o = 3'b000;

endmodule

`default_nettype wire

//--- verilog/mem_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_bridge_defines.svh"

module mem_fifo
  #(parameter type payload_t = logic)
  (
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire logic     push_i,
    input  wire payload_t data_i,
    input  wire logic     yumi_i,
    output logic          ready_o,
    output logic          v_o,
    output payload_t      data_o
  );

  localparam int DEPTH = `MEM_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic [CNT_W-1:0] count_n;
  logic             v_r;
  logic             ready_r;

  always_comb
  begin
    count_n = count_r;
    if (push_i && !yumi_i)
      count_n = count_r + 1'b1;
    else if (!push_i && yumi_i)
      count_n = count_r - 1'b1;
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      v_r      <= 1'b0;
      ready_r  <= 1'b1;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (yumi_i)
        rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_n;
      v_r     <= (count_n != '0);
      ready_r <= (count_n != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r] <= data_i;
  end

  assign data_o  = mem_r[rd_ptr_r];
  assign v_o     = v_r;
  assign ready_o = ready_r;

  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> ready_o);
  a_no_yumi_empty: assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o);

endmodule

`default_nettype wire
